// ==== src/ibuf_extract.sv ====
`timescale 1ns/1ps

module ibuf_extract (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    redirect_i,
    input  logic [ibuf_pkg::ADDR_W-1:0]             redirect_addr_i,
    input  logic [ibuf_pkg::NUM_SLOTS-1:0]          slot_valid_i,
    input  logic [ibuf_pkg::NUM_SLOTS*ibuf_pkg::LINE_W-1:0] slot_data_i,
    input  logic                                    dec_ack_i,
    input  logic [ibuf_pkg::LEN_W-1:0]              dec_len_i,
    output logic                                    dec_req_o,
    output logic [ibuf_pkg::ADDR_W-1:0]             dec_addr_o,
    output logic [ibuf_pkg::WIN_BYTES*8-1:0]        dec_bytes_o,
    output logic                                    advance_o,
    output ibuf_pkg::ibuf_ptr_u                     old_ptr_o,
    output ibuf_pkg::ibuf_ptr_u                     new_ptr_o
);

    logic [1:0]                       state_q;
    logic [ibuf_pkg::ADDR_W-1:0]      dec_addr_q;
    logic                             advance_q;
    ibuf_pkg::ibuf_ptr_u              old_ptr_q;
    ibuf_pkg::ibuf_ptr_u              new_ptr_q;
    ibuf_pkg::ibuf_ptr_u              ptr;
    logic [ibuf_pkg::SLOT_W-1:0]      nxt_slot;
    logic                             crosses;
    logic                             ready;
    logic [2*ibuf_pkg::LINE_W-1:0]    pair_bytes;
    logic [2*ibuf_pkg::LINE_W-1:0]    shifted;

    assign ptr.flat = dec_addr_q[ibuf_pkg::PTR_W-1:0];
    assign nxt_slot = ptr.f.slot + 1'b1; // slot 11 wraps to 00

    // last window byte sits in the next slot
    assign crosses = ptr.f.offset > ibuf_pkg::OFF_W'(ibuf_pkg::LINE_BYTES - ibuf_pkg::WIN_BYTES);
    assign ready   = slot_valid_i[ptr.f.slot] && (!crosses || slot_valid_i[nxt_slot]);

    assign pair_bytes = {slot_data_i[nxt_slot*ibuf_pkg::LINE_W +: ibuf_pkg::LINE_W],
                         slot_data_i[ptr.f.slot*ibuf_pkg::LINE_W +: ibuf_pkg::LINE_W]};
    assign shifted     = pair_bytes >> {ptr.f.offset, 3'b000};
    assign dec_bytes_o = shifted[ibuf_pkg::WIN_BYTES*8-1:0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= ibuf_pkg::ST_IDLE;
            dec_addr_q <= ibuf_pkg::RESET_ADDR;
            advance_q  <= 1'b0;
        end else begin
            advance_q <= 1'b0;
            case (state_q)
                ibuf_pkg::ST_IDLE: begin
                    if (ready && !redirect_i) begin
                        state_q <= ibuf_pkg::ST_WAIT_HI;
                    end
                end
                ibuf_pkg::ST_WAIT_HI: begin
                    if (dec_ack_i) begin
                        state_q    <= ibuf_pkg::ST_WAIT_LO;
                        dec_addr_q <= dec_addr_q + ibuf_pkg::ADDR_W'(dec_len_i);
                        advance_q  <= 1'b1;
                    end
                end
                ibuf_pkg::ST_WAIT_LO: begin
                    if (!dec_ack_i) begin
                        state_q <= ibuf_pkg::ST_IDLE;
                    end
                end
                default: state_q <= ibuf_pkg::ST_IDLE;
            endcase
            if (redirect_i) begin
                dec_addr_q <= redirect_addr_i;
            end
        end
    end

    // pointer pair for the latch, only meaningful with advance_o
    always_ff @(posedge clk) begin
        if ((state_q == ibuf_pkg::ST_WAIT_HI) && dec_ack_i) begin
            old_ptr_q      <= ptr;
            new_ptr_q.flat <= ptr.flat + ibuf_pkg::PTR_W'(dec_len_i);
        end
    end

    assign dec_req_o  = (state_q == ibuf_pkg::ST_WAIT_HI);
    assign dec_addr_o = dec_addr_q;
    assign advance_o  = advance_q;
    assign old_ptr_o  = old_ptr_q;
    assign new_ptr_o  = new_ptr_q;

endmodule

// ==== src/ibuf_latch.sv ====
`timescale 1ns/1ps

module ibuf_latch (
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    redirect_i,
    input  logic                                    wr_even_i,
    input  logic                                    wr_odd_i,
    input  logic                                    pair_hi_i,
    input  logic [ibuf_pkg::LINE_W-1:0]             line_even_i,
    input  logic [ibuf_pkg::LINE_W-1:0]             line_odd_i,
    input  logic                                    advance_i,
    input  ibuf_pkg::ibuf_ptr_u                     old_ptr_i,
    input  ibuf_pkg::ibuf_ptr_u                     new_ptr_i,
    output logic [ibuf_pkg::NUM_SLOTS-1:0]          slot_valid_o,
    output logic [ibuf_pkg::NUM_SLOTS*ibuf_pkg::LINE_W-1:0] slot_data_o
);

    logic [ibuf_pkg::LINE_W-1:0]    slot_q [ibuf_pkg::NUM_SLOTS];
    logic [ibuf_pkg::NUM_SLOTS-1:0] valid_q;
    logic [ibuf_pkg::NUM_SLOTS-1:0] ld;
    logic [ibuf_pkg::NUM_SLOTS-1:0] inv;
    logic                           crossed;

    // offset wrapped around, so the pointer left the old slot
    assign crossed = advance_i && (new_ptr_i.f.offset < old_ptr_i.f.offset);

    always_comb begin
        for (int k = 0; k < ibuf_pkg::NUM_SLOTS; k++) begin
            // even strobe goes to 00/10, odd to 01/11, never over a live line
            ld[k]  = !valid_q[k] && (pair_hi_i == k[1])
                  && (k[0] ? wr_odd_i : wr_even_i);
            inv[k] = crossed && (old_ptr_i.f.slot == ibuf_pkg::SLOT_W'(k));
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (redirect_i) begin
            valid_q <= '0; // wins over a load in the same cycle
        end else begin
            for (int k = 0; k < ibuf_pkg::NUM_SLOTS; k++) begin
                if (ld[k]) begin
                    valid_q[k] <= 1'b1;
                end else if (inv[k]) begin
                    valid_q[k] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < ibuf_pkg::NUM_SLOTS; k++) begin
            if (ld[k]) begin
                slot_q[k] <= k[0] ? line_odd_i : line_even_i;
            end
        end
    end

    always_comb begin
        for (int k = 0; k < ibuf_pkg::NUM_SLOTS; k++) begin
            slot_data_o[k*ibuf_pkg::LINE_W +: ibuf_pkg::LINE_W] = slot_q[k];
        end
    end

    assign slot_valid_o = valid_q;

endmodule

// ==== src/ibuf_pkg.sv ====
package ibuf_pkg;

    localparam int ADDR_W     = 32;
    localparam int LINE_BYTES = 16;
    localparam int LINE_W     = LINE_BYTES * 8;
    localparam int NUM_SLOTS  = 4;
    localparam int WIN_BYTES  = 8;
    localparam int LEN_W      = 4;

    // pointer fields, slot is address bits 5:4
    localparam int SLOT_W = 2;
    localparam int OFF_W  = 4;
    localparam int PTR_W  = SLOT_W + OFF_W;

    // one memory transaction returns an even/odd line pair
    localparam int PAIR_BYTES = 2 * LINE_BYTES;
    localparam logic [ADDR_W-1:0] PAIR_MASK = ~ADDR_W'(PAIR_BYTES - 1);

    localparam logic [ADDR_W-1:0] RESET_ADDR = '0;

    // four-phase handshake states, shared by fetcher and extractor
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_WAIT_HI = 2'd1; // req up, waiting for ack
    localparam logic [1:0] ST_WAIT_LO = 2'd2; // req down, waiting for ack to drop

    // low 6 bits of the decode address
    typedef union packed {
        logic [PTR_W-1:0] flat;
        struct packed {
            logic [SLOT_W-1:0] slot;
            logic [OFF_W-1:0]  offset;
        } f;
    } ibuf_ptr_u;

endpackage

// ==== src/ibuf_top.sv ====
`timescale 1ns/1ps

module ibuf_top (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              redirect_i,
    input  logic [ibuf_pkg::ADDR_W-1:0]       redirect_addr_i,
    output logic                              mem_req_o,
    output logic [ibuf_pkg::ADDR_W-1:0]       mem_addr_o,
    input  logic                              mem_ack_i,
    input  logic [ibuf_pkg::LINE_W-1:0]       mem_line_even_i,
    input  logic [ibuf_pkg::LINE_W-1:0]       mem_line_odd_i,
    output logic                              dec_req_o,
    output logic [ibuf_pkg::ADDR_W-1:0]       dec_addr_o,
    output logic [ibuf_pkg::WIN_BYTES*8-1:0]  dec_bytes_o,
    input  logic                              dec_ack_i,
    input  logic [ibuf_pkg::LEN_W-1:0]        dec_len_i,
    output logic [ibuf_pkg::NUM_SLOTS-1:0]    slot_valid_o
);

    logic                                             wr_even;
    logic                                             wr_odd;
    logic                                             pair_hi;
    logic [ibuf_pkg::LINE_W-1:0]                      line_even;
    logic [ibuf_pkg::LINE_W-1:0]                      line_odd;
    logic [ibuf_pkg::NUM_SLOTS-1:0]                   slot_valid;
    logic [ibuf_pkg::NUM_SLOTS*ibuf_pkg::LINE_W-1:0]  slot_data;
    logic                                             advance;
    ibuf_pkg::ibuf_ptr_u                              old_ptr;
    ibuf_pkg::ibuf_ptr_u                              new_ptr;

    line_fetcher line_fetcher_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .redirect_i      (redirect_i),
        .redirect_addr_i (redirect_addr_i),
        .slot_valid_i    (slot_valid),
        .mem_ack_i       (mem_ack_i),
        .mem_line_even_i (mem_line_even_i),
        .mem_line_odd_i  (mem_line_odd_i),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .wr_even_o       (wr_even),
        .wr_odd_o        (wr_odd),
        .pair_hi_o       (pair_hi),
        .line_even_o     (line_even),
        .line_odd_o      (line_odd)
    );

    ibuf_latch ibuf_latch_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .redirect_i   (redirect_i),
        .wr_even_i    (wr_even),
        .wr_odd_i     (wr_odd),
        .pair_hi_i    (pair_hi),
        .line_even_i  (line_even),
        .line_odd_i   (line_odd),
        .advance_i    (advance),
        .old_ptr_i    (old_ptr),
        .new_ptr_i    (new_ptr),
        .slot_valid_o (slot_valid),
        .slot_data_o  (slot_data)
    );

    ibuf_extract ibuf_extract_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .redirect_i      (redirect_i),
        .redirect_addr_i (redirect_addr_i),
        .slot_valid_i    (slot_valid),
        .slot_data_i     (slot_data),
        .dec_ack_i       (dec_ack_i),
        .dec_len_i       (dec_len_i),
        .dec_req_o       (dec_req_o),
        .dec_addr_o      (dec_addr_o),
        .dec_bytes_o     (dec_bytes_o),
        .advance_o       (advance),
        .old_ptr_o       (old_ptr),
        .new_ptr_o       (new_ptr)
    );

    assign slot_valid_o = slot_valid;

endmodule

// ==== src/line_fetcher.sv ====
`timescale 1ns/1ps

module line_fetcher (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           redirect_i,
    input  logic [ibuf_pkg::ADDR_W-1:0]    redirect_addr_i,
    input  logic [ibuf_pkg::NUM_SLOTS-1:0] slot_valid_i,
    input  logic                           mem_ack_i,
    input  logic [ibuf_pkg::LINE_W-1:0]    mem_line_even_i,
    input  logic [ibuf_pkg::LINE_W-1:0]    mem_line_odd_i,
    output logic                           mem_req_o,
    output logic [ibuf_pkg::ADDR_W-1:0]    mem_addr_o,
    output logic                           wr_even_o,
    output logic                           wr_odd_o,
    output logic                           pair_hi_o,
    output logic [ibuf_pkg::LINE_W-1:0]    line_even_o,
    output logic [ibuf_pkg::LINE_W-1:0]    line_odd_o
);

    logic [1:0]                  state_q;
    logic [ibuf_pkg::ADDR_W-1:0] fetch_addr_q; // next pair to fetch, 32-byte aligned
    logic [ibuf_pkg::ADDR_W-1:0] req_addr_q;   // held while req is up
    logic                        skip_even_q;
    logic                        discard_q;
    logic                        wr_even_q;
    logic                        wr_odd_q;
    logic [ibuf_pkg::LINE_W-1:0] line_even_q;
    logic [ibuf_pkg::LINE_W-1:0] line_odd_q;
    logic                        room;
    logic                        ack_seen;

    // address bit 5 picks slots 00/01 or 10/11
    assign room = !slot_valid_i[{fetch_addr_q[5], 1'b1}]
               && (skip_even_q || !slot_valid_i[{fetch_addr_q[5], 1'b0}]);

    assign ack_seen = (state_q == ibuf_pkg::ST_WAIT_HI) && mem_ack_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q      <= ibuf_pkg::ST_IDLE;
            fetch_addr_q <= ibuf_pkg::RESET_ADDR & ibuf_pkg::PAIR_MASK;
            req_addr_q   <= ibuf_pkg::RESET_ADDR & ibuf_pkg::PAIR_MASK;
            skip_even_q  <= ibuf_pkg::RESET_ADDR[4];
            discard_q    <= 1'b0;
            wr_even_q    <= 1'b0;
            wr_odd_q     <= 1'b0;
        end else begin
            wr_even_q <= 1'b0;
            wr_odd_q  <= 1'b0;
            case (state_q)
                ibuf_pkg::ST_IDLE: begin
                    if (room && !redirect_i) begin
                        state_q    <= ibuf_pkg::ST_WAIT_HI;
                        req_addr_q <= fetch_addr_q;
                    end
                end
                ibuf_pkg::ST_WAIT_HI: begin
                    if (mem_ack_i) begin
                        state_q   <= ibuf_pkg::ST_WAIT_LO;
                        wr_even_q <= !discard_q && !redirect_i && !skip_even_q;
                        wr_odd_q  <= !discard_q && !redirect_i;
                    end
                end
                ibuf_pkg::ST_WAIT_LO: begin
                    if (!mem_ack_i) begin
                        state_q   <= ibuf_pkg::ST_IDLE;
                        discard_q <= 1'b0;
                        if (!discard_q) begin // a discarded pair leaves the new address alone
                            fetch_addr_q <= fetch_addr_q + ibuf_pkg::ADDR_W'(ibuf_pkg::PAIR_BYTES);
                            skip_even_q  <= 1'b0;
                        end
                    end
                end
                default: state_q <= ibuf_pkg::ST_IDLE;
            endcase
            if (redirect_i) begin
                fetch_addr_q <= redirect_addr_i & ibuf_pkg::PAIR_MASK;
                skip_even_q  <= redirect_addr_i[4];
                // transaction still open, let it finish without writing
                discard_q    <= (state_q == ibuf_pkg::ST_WAIT_HI)
                             || ((state_q == ibuf_pkg::ST_WAIT_LO) && mem_ack_i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ack_seen) begin
            line_even_q <= mem_line_even_i;
            line_odd_q  <= mem_line_odd_i;
        end
    end

    assign mem_req_o   = (state_q == ibuf_pkg::ST_WAIT_HI);
    assign mem_addr_o  = req_addr_q;
    assign wr_even_o   = wr_even_q;
    assign wr_odd_o    = wr_odd_q;
    assign pair_hi_o   = req_addr_q[5];
    assign line_even_o = line_even_q;
    assign line_odd_o  = line_odd_q;

endmodule

// ==== tests/ibuf_tb.sv ====
`timescale 1ns/1ps

module ibuf_tb;

    logic                             clk;
    logic                             rst_i;
    logic                             redirect_i;
    logic [ibuf_pkg::ADDR_W-1:0]      redirect_addr_i;
    logic                             mem_req_o;
    logic [ibuf_pkg::ADDR_W-1:0]      mem_addr_o;
    logic                             mem_ack_i;
    logic [ibuf_pkg::LINE_W-1:0]      mem_line_even_i;
    logic [ibuf_pkg::LINE_W-1:0]      mem_line_odd_i;
    logic                             dec_req_o;
    logic [ibuf_pkg::ADDR_W-1:0]      dec_addr_o;
    logic [ibuf_pkg::WIN_BYTES*8-1:0] dec_bytes_o;
    logic                             dec_ack_i;
    logic [ibuf_pkg::LEN_W-1:0]       dec_len_i;
    logic [ibuf_pkg::NUM_SLOTS-1:0]   slot_valid_o;

    logic [95:0]                      tags [32];
    logic [ibuf_pkg::ADDR_W-1:0]      starts [32];
    int                               counts [32];
    int                               max_lens [32];
    int                               num_tests;
    int                               total_insns;
    bit                               loaded;
    int                               errors;
    int                               errs_before;
    int                               passed;
    int                               failed;
    logic [ibuf_pkg::ADDR_W-1:0]      exp_addr;
    logic [ibuf_pkg::ADDR_W-1:0]      last_redir;
    logic [ibuf_pkg::ADDR_W-1:0]      decoy_pair;
    logic                             mem_req_q;
    logic                             dec_req_q;
    logic                             mem_ack_q;
    logic                             dec_ack_q;
    logic [ibuf_pkg::ADDR_W-1:0]      mem_addr_q;
    logic [ibuf_pkg::WIN_BYTES*8-1:0] dec_bytes_q;

    ibuf_top ibuf_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory image, all address bytes folded together and xored with a5
    function automatic logic [ibuf_pkg::LINE_W-1:0] pattern(input logic [31:0] base);
        logic [ibuf_pkg::LINE_W-1:0] r;
        logic [31:0]                 a;
        for (int b = 0; b < ibuf_pkg::LINE_BYTES; b++) begin
            a = base + b;
            r[8*b +: 8] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        logic [639:0] text;
        logic [95:0] tag;
        logic [31:0] start;
        int          count;
        int          max_len;
        num_tests   = 0;
        total_insns = 0;
        fd = $fopen("tests/ibuf_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/ibuf_testdata.txt");
        end else begin
            while (!$feof(fd) && num_tests < 32) begin
                n = $fgets(text, fd);
                if (n > 0 && $sscanf(text, "%s %h %d %d", tag, start, count, max_len) == 4) begin
                    tags[num_tests]     = tag;
                    starts[num_tests]   = start;
                    counts[num_tests]   = count;
                    max_lens[num_tests] = (max_len < 1) ? 1 : max_len;
                    total_insns += count;
                    num_tests++;
                end
            end
            $fclose(fd);
        end
        if (num_tests == 0) $display("no test lines could be read from the data file");
        loaded = 1'b1;
    endtask

    task automatic send_redirect(input logic [ibuf_pkg::ADDR_W-1:0] addr);
        redirect_i      <= 1'b1;
        redirect_addr_i <= addr;
        last_redir      <= addr;
        @(posedge clk);
        redirect_i <= 1'b0;
    endtask

    // plays the decoder for one test
    task automatic run_decode(input int count, input int max_len, input bit skip_even);
        int                          delay;
        int                          len;
        logic [ibuf_pkg::LINE_W-1:0] exp_line;
        for (int i = 0; i < count; i++) begin
            while (!dec_req_o) @(posedge clk);
            exp_line = pattern(exp_addr);
            check_value("dec_addr_o", exp_addr, dec_addr_o);
            check_value("dec_bytes_o", exp_line[63:0], dec_bytes_o);
            if (i == 0 && skip_even) begin // even half of the first pair stays empty
                check_value("slot_valid_o below start", 0, slot_valid_o[{exp_addr[5], 1'b0}]);
            end
            delay = $urandom % 5;
            repeat (delay) @(posedge clk);
            len = 1 + $urandom % max_len;
            dec_ack_i <= 1'b1;
            dec_len_i <= ibuf_pkg::LEN_W'(len);
            @(posedge clk);
            while (dec_req_o) @(posedge clk);
            dec_ack_i <= 1'b0;
            exp_addr = exp_addr + len;
        end
    endtask

    // memory side, random latency before ack
    initial begin
        forever begin
            @(posedge clk);
            if (mem_req_o && !mem_ack_i) begin
                repeat ($urandom % 6) @(posedge clk);
                mem_line_even_i <= pattern(mem_addr_o);
                mem_line_odd_i  <= pattern(mem_addr_o + ibuf_pkg::LINE_BYTES);
                mem_ack_i       <= 1'b1;
                @(posedge clk);
                while (mem_req_o) @(posedge clk);
                mem_ack_i <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        mem_req_q   <= mem_req_o;
        dec_req_q   <= dec_req_o;
        mem_ack_q   <= mem_ack_i;
        dec_ack_q   <= dec_ack_i;
        mem_addr_q  <= mem_addr_o;
        dec_bytes_q <= dec_bytes_o;
        if (!rst_i) begin
            if (mem_req_o && !mem_req_q) begin
                check_value("mem_ack_i before mem_req_o rise", 0, mem_ack_q);
                check_value("odd slot valid at mem_req_o rise", 0,
                            slot_valid_o[{mem_addr_o[5], 1'b1}]);
                if (!(last_redir[4] && mem_addr_o == (last_redir & ibuf_pkg::PAIR_MASK))) begin
                    check_value("even slot valid at mem_req_o rise", 0,
                                slot_valid_o[{mem_addr_o[5], 1'b0}]);
                end
            end
            if (mem_req_o && mem_req_q) check_value("mem_addr_o", mem_addr_q, mem_addr_o);
            if (dec_req_o && !dec_req_q) begin
                check_value("dec_ack_i before dec_req_o rise", 0, dec_ack_q);
            end
            if (dec_req_o && dec_req_q) check_value("dec_bytes_o", dec_bytes_q, dec_bytes_o);
        end
    end

    initial begin
        wait (loaded);
        repeat (total_insns * 60 + 1000) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung", total_insns * 60 + 1000);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(40));
        rst_i           = 1'b1;
        redirect_i      = 1'b0;
        redirect_addr_i = '0;
        mem_ack_i       = 1'b0;
        mem_line_even_i = '0;
        mem_line_odd_i  = '0;
        dec_ack_i       = 1'b0;
        dec_len_i       = '0;
        errors          = 0;
        passed          = 0;
        failed          = 0;
        last_redir      = ibuf_pkg::RESET_ADDR;
        load_tests();
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        for (int t = 0; t < num_tests; t++) begin
            errs_before = errors;
            if (t == 0) begin
                check_value("mem_req_o after reset", 0, mem_req_o);
                check_value("dec_req_o after reset", 0, dec_req_o);
                check_value("slot_valid_o after reset", 0, slot_valid_o);
                check_value("dec_addr_o after reset", ibuf_pkg::RESET_ADDR, dec_addr_o);
                exp_addr = ibuf_pkg::RESET_ADDR;
            end else begin
                if (tags[t] == "open") begin
                    // decoy pair is still being fetched when the real redirect lands
                    decoy_pair = (starts[t] + 32'h40) & ibuf_pkg::PAIR_MASK;
                    send_redirect(starts[t] + 32'h40);
                    @(posedge clk);
                    while (!mem_req_o || mem_addr_o != decoy_pair) @(posedge clk);
                end
                send_redirect(starts[t]);
                exp_addr = starts[t];
            end
            run_decode(counts[t], max_lens[t], (t > 0) && starts[t][4]);
            if (errors == errs_before) begin
                passed++;
            end else begin
                failed++;
            end
            $display("test %0d %0s start %h: %0d instructions, %0d errors",
                     t, tags[t], (t == 0) ? ibuf_pkg::RESET_ADDR : starts[t], counts[t],
                     errors - errs_before);
        end
        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0 && num_tests > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/ibuf_testdata.txt ====
# tag  start_addr(hex)  instruction_count  max_length
# every test after the first begins with a redirect to its start address
straight  00000000  40  8
odd_half  00000113  30  6
open      00000230  30  8
unalign   0000040b  40  3
bytewise  00000805  40  1
wrap4k    00000ff9  40  8
open      00001027  30  5
long      00002000  50  8

// ==== vlog.f ====
src/ibuf_pkg.sv
src/line_fetcher.sv
src/ibuf_latch.sv
src/ibuf_extract.sv
src/ibuf_top.sv
tests/ibuf_tb.sv
